/* tb.f */
ahbCachePkg.sv
busCacheFsm.sv
beatCounter.sv
fetchBuffer.sv
busWordSelect.sv
ahbCacheBus.sv
ahbMemModel.sv
busCacheProps.sv
tbAhbCacheBus.sv

/* Makefile */
# Verilator simulation of the AHB cache bus master

VERILATOR ?= verilator
TOP       ?= tbAhbCacheBus
FILELIST  ?= tb.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove build output"
	@echo "  help   list targets"

$(BUILD)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* tbAhbCacheBus.sv */
/*
  Testbench for the AHB cache bus master. Runs a table of uncached and
  line operations against a memory model with optional wait states
*/
`timescale 1ns/1ps
`default_nettype none

module tbAhbCacheBus import ahbCachePkg::*; ();

  localparam int Beats   = 4;
  localparam int NumRows = 13;
  localparam int Timeout = NumRows * 2 * (Beats + 2) * 4 + 50;   // Chained rows move 2 lines
  localparam logic [2:0] KRead = 0, KWrite = 1, KFetch = 2, KWback = 3, KChain = 4;

  typedef wordT [Beats-1:0] lineT;
  typedef struct packed {
    logic [2:0]  kind;
    logic [31:0] addr;
    wordT        data;                    // Write word or line seed
    logic        randWait;
  } rowT;

  logic HCLK = 0, rstN = 0, stall = 1, HREADY = 1, randWait = 0;
  busOpT busOp = NoOp;
  cacheOpT cacheOp = NoCacheOp;
  logic [31:0] paddr = '0, HADDR;
  wordT writeWord = '0, readWord, HRDATA, HWDATA;
  lineT writeLine = '0, fetchLine;
  logic busStall, cacheBusAck, HWRITE;
  logic [2:0] HBURST;
  ahbTransT HTRANS;
  wordT shadow [64];
  logic [31:0] lfsr = 32'h79b73a6a;
  int cycles = 0;

  rowT rows [NumRows] = '{
    '{KRead, 32'h10, 32'h0, 1'b0}, '{KWrite, 32'h24, 32'h12345678, 1'b0},
    '{KRead, 32'h24, 32'h0, 1'b0}, '{KFetch, 32'h40, 32'h0, 1'b0},
    '{KChain, 32'h80, 32'hC0DE0000, 1'b0}, '{KWback, 32'h50, 32'h5EED0000, 1'b0},
    '{KFetch, 32'h50, 32'h0, 1'b0}, '{KRead, 32'h14, 32'h0, 1'b1},
    '{KWrite, 32'h28, 32'hCAFEF00D, 1'b1}, '{KRead, 32'h28, 32'h0, 1'b1},
    '{KFetch, 32'h60, 32'h0, 1'b1}, '{KChain, 32'hC0, 32'hBEEF0000, 1'b1},
    '{KFetch, 32'h80, 32'h0, 1'b1}
  };

  ahbCacheBus #(.BeatsPerLine(Beats), .BurstEn(1'b1)) UUT (.*);
  ahbMemModel #(.Words(64)) mem (.*);

  always #2 HCLK = ~HCLK;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR bit per cycle for wait states in random rows
  always @(posedge HCLK) begin
    logic waitNow;
    waitNow = randWait;
    #0.5;
    if (waitNow) begin
      lfsr = lfsrStep(lfsr);
      HREADY = ~lfsr[0];
    end else HREADY = 1'b1;
  end

  always @(posedge HCLK) begin
    cycles++;
    if (cycles > Timeout) begin
      $display("Timeout: no response from the bus master within %0d cycles", Timeout);
      stopOnFailure();
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////
  task automatic stopOnFailure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      stopOnFailure();
    end
  endtask

  task automatic checkLine(input string name, input lineT got, input lineT exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      stopOnFailure();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      stopOnFailure();
    end
  endtask

  task automatic checkTrans(input string name, input ahbTransT got, input ahbTransT exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      stopOnFailure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // One table row
  ////////////////////////////////////////////////////////////////////////
  task automatic runRow(input rowT r);
    lineT wl, exp;
    int idx, acks, needAcks;
    idx = int'(r.addr[7:2]);
    for (int b = 0; b < Beats; b++) wl[b] = r.data + wordT'(b);
    @(posedge HCLK);
    #0.5;
    paddr     = r.addr;
    writeWord = r.data;
    writeLine = wl;
    randWait  = r.randWait;
    stall     = 1;
    case (r.kind)
      KRead:   busOp = ReadOp;
      KWrite:  busOp = WriteOp;
      KFetch:  cacheOp = FetchOp;
      KWback:  cacheOp = WritebackOp;
      default: cacheOp = cacheOpT'(2'b11);   // Writeback chained into fetch
    endcase
    if (r.kind == KRead || r.kind == KWrite) begin
      do @(negedge HCLK); while (busStall);
      if (r.kind == KRead) checkWord("readWord", readWord, shadow[idx]);
      else shadow[idx] = r.data;
      @(posedge HCLK);
      #0.5;
      busOp = NoOp;                       // Core takes the result
      stall = 0;
      @(posedge HCLK);
      #0.5 stall = 1;
    end else begin
      needAcks = (r.kind == KChain) ? 2 : 1;
      acks = 0;
      while (acks < needAcks) begin
        @(negedge HCLK);
        if (cacheBusAck) acks++;
      end
      @(posedge HCLK);
      #0.5 cacheOp = NoCacheOp;
      if (r.kind != KFetch) for (int b = 0; b < Beats; b++) shadow[idx + b] = wl[b];
      if (r.kind != KWback) begin
        for (int b = 0; b < Beats; b++) exp[b] = shadow[idx + b];
        @(negedge HCLK);
        checkLine("fetchLine", fetchLine, exp);
      end
    end
  endtask

  initial begin
    for (int i = 0; i < 64; i++) shadow[i] = wordT'(i) ^ 32'hA5A50000;
    repeat (4) @(posedge HCLK);
    #0.5 rstN = 1;
    repeat (3) begin                      // Quiet bus after reset
      @(negedge HCLK);
      checkTrans("HTRANS", HTRANS, TransIdle);
      checkFlag("busStall", busStall, 1'b0);
      checkFlag("cacheBusAck", cacheBusAck, 1'b0);
    end
    foreach (rows[i]) runRow(rows[i]);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* busCacheProps.sv */
/*
  AHB protocol checks on the cache bus master, bound to its top level
*/
`timescale 1ns/1ps
`default_nettype none

module busCacheProps import ahbCachePkg::*; #(
  parameter int BeatsPerLine = 4,
  localparam int CountBits   = $clog2(BeatsPerLine)
) (
  input logic                 HCLK,
  input logic                 rstN,
  input logic                 HREADY,
  input logic                 cacheBusAck,
  input logic                 selBusBeat,
  input logic [CountBits-1:0] beatCount,
  input ahbTransT             HTRANS,
  input logic                 HWRITE,
  input logic [2:0]           HBURST,
  input logic [31:0]          HADDR
);

  logic        lineBeat;                  // Line address phase on the bus
  int          phaseCnt;                  // Accepted phases of this line
  logic [31:0] lastAddr;

  assign lineBeat = selBusBeat && (HTRANS != TransIdle);

  always @(posedge HCLK) begin
    if (!rstN) begin
      phaseCnt <= 0;
      lastAddr <= '0;
    end else if (HREADY && lineBeat) begin
      phaseCnt <= (HTRANS == TransNonseq) ? 1 : phaseCnt + 1;
      lastAddr <= HADDR;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Protocol rules
  ////////////////////////////////////////////////////////////////////
  aBeats: assert property (@(posedge HCLK) disable iff (!rstN)
    cacheBusAck |-> phaseCnt == BeatsPerLine) else $error("line beat count");
  aFirst: assert property (@(posedge HCLK) disable iff (!rstN)
    lineBeat && beatCount == '0 |-> HTRANS == TransNonseq) else $error("first beat");
  aLater: assert property (@(posedge HCLK) disable iff (!rstN)
    lineBeat && beatCount != '0 |-> HTRANS == TransSeq) else $error("later beat");
  aStep: assert property (@(posedge HCLK) disable iff (!rstN)
    lineBeat && HTRANS == TransSeq |-> HADDR == lastAddr + 32'd4) else $error("addr step");
  aBurst: assert property (@(posedge HCLK) disable iff (!rstN)
    lineBeat |-> HBURST == 3'b011) else $error("burst type");   // INCR4
  aHold: assert property (@(posedge HCLK) disable iff (!rstN)
    HTRANS != TransIdle && !HREADY |=> $stable(HTRANS) && $stable(HADDR) && $stable(HWRITE))
    else $error("wait hold");

endmodule

bind ahbCacheBus busCacheProps #(.BeatsPerLine(BeatsPerLine)) props (
  .HCLK, .rstN, .HREADY, .cacheBusAck, .selBusBeat, .beatCount,
  .HTRANS, .HWRITE, .HBURST, .HADDR
);

`default_nettype wire

/* ahbMemModel.sv */
/*
  AHB slave model for the testbench, one word-wide memory with
  address and data phases, HREADY comes from outside
*/
`timescale 1ns/1ps
`default_nettype none

module ahbMemModel import ahbCachePkg::*; #(
  parameter int Words = 64
) (
  input  logic        HCLK,
  input  logic        rstN,
  input  logic        HREADY,
  input  ahbTransT    HTRANS,
  input  logic        HWRITE,
  input  logic [31:0] HADDR,
  input  wordT        HWDATA,
  output wordT        HRDATA
);

  localparam int IdxBits = $clog2(Words);

  wordT               mem [Words];
  logic               dataValid;          // Data phase in progress
  logic               dataWrite;
  logic [IdxBits-1:0] dataIdx;

  // Preset pattern, word index XOR a marker
  initial begin
    for (int i = 0; i < Words; i++) mem[i] = wordT'(i) ^ 32'hA5A50000;
  end

  always @(posedge HCLK) begin
    if (!rstN) begin
      dataValid <= 1'b0;
      dataWrite <= 1'b0;
      dataIdx   <= '0;
    end else if (HREADY) begin
      if (dataValid && dataWrite) mem[dataIdx] <= HWDATA;   // Write completes
      dataValid <= (HTRANS == TransNonseq) || (HTRANS == TransSeq);
      dataWrite <= HWRITE;
      dataIdx   <= HADDR[IdxBits+1:2];
    end
  end

  assign HRDATA = mem[dataIdx];

endmodule

`default_nettype wire

/* ahbCacheBus.sv */
/*
  AHB bus master for a cache and uncached core accesses, 32-bit data,
  single words and line bursts
*/
`timescale 1ns/1ps
`default_nettype none

module ahbCacheBus import ahbCachePkg::*; #(
  parameter int BeatsPerLine = 4,
  parameter bit BurstEn      = 1'b1,
  localparam int CountBits   = $clog2(BeatsPerLine)
) (
  input  logic                    HCLK,
  input  logic                    rstN,
  // Core side
  input  logic                    stall,
  input  busOpT                   busOp,
  input  logic [31:0]             paddr,
  input  wordT                    writeWord,
  output wordT                    readWord,
  output logic                    busStall,
  // Cache side
  input  cacheOpT                 cacheOp,
  input  wordT [BeatsPerLine-1:0] writeLine,
  output wordT [BeatsPerLine-1:0] fetchLine,
  output logic                    cacheBusAck,
  // AHB
  input  logic                    HREADY,
  input  wordT                    HRDATA,
  output logic [31:0]             HADDR,
  output wordT                    HWDATA,
  output ahbTransT                HTRANS,
  output logic                    HWRITE,
  output logic [2:0]              HBURST
);

  ahbCtrlT              ahbCtrl;
  logic                 captureEn, selBusBeat;
  logic                 cntEn, cntReset;
  logic [CountBits-1:0] beatCount, beatCountDelayed;
  logic                 finalBeat;

  ////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////
  busCacheFsm #(.BeatsPerLine(BeatsPerLine), .BurstEn(BurstEn)) fsm (
    .HCLK, .rstN, .stall, .busOp, .cacheOp, .HREADY, .beatCount, .finalBeat,
    .ahbCtrl, .busStall, .cacheBusAck, .captureEn, .selBusBeat, .cntEn, .cntReset
  );

  beatCounter #(.BeatsPerLine(BeatsPerLine)) beatCnt (
    .HCLK, .rstN, .cntEn, .cntReset, .beatCount, .beatCountDelayed, .finalBeat
  );

  ////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////
  // selBusBeat is high exactly on line states, so it marks line capture
  fetchBuffer #(.BeatsPerLine(BeatsPerLine)) fetchBuf (
    .HCLK, .rstN, .captureEn, .isLine(selBusBeat), .beatCountDelayed, .HRDATA,
    .fetchLine, .readWord
  );

  busWordSelect #(.BeatsPerLine(BeatsPerLine)) wordSel (
    .HCLK, .rstN, .HREADY, .selBusBeat, .beatCount, .paddr, .writeWord, .writeLine,
    .HADDR, .HWDATA
  );

  // Control bundle out to the bus pins
  assign HTRANS = ahbCtrl.trans;
  assign HWRITE = ahbCtrl.write;
  assign HBURST = ahbCtrl.burst;

endmodule

`default_nettype wire

/* busWordSelect.sv */
/*
  Address and write data path. Builds HADDR from the request address
  or the line beat, and registers HWDATA for the data phase
*/
`timescale 1ns/1ps
`default_nettype none

module busWordSelect import ahbCachePkg::*; #(
  parameter int BeatsPerLine = 4,           // Power of two, 2 or more
  localparam int CountBits   = $clog2(BeatsPerLine)
) (
  input  logic                    HCLK,
  input  logic                    rstN,
  input  logic                    HREADY,
  input  logic                    selBusBeat,
  input  logic [CountBits-1:0]    beatCount,
  input  logic [31:0]             paddr,
  input  wordT                    writeWord,    // Uncached store data
  input  wordT [BeatsPerLine-1:0] writeLine,    // Victim line
  output logic [31:0]             HADDR,
  output wordT                    HWDATA
);

  localparam int OffBits = CountBits + 2;   // Byte offset within a line

  logic [31:0] beatAddr;
  wordT        nextWdata;

  ////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////
  // Line base with beat index as word offset
  assign beatAddr = {paddr[31:OffBits], beatCount, 2'b00};
  assign HADDR    = selBusBeat ? beatAddr : paddr;

  ////////////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////////////
  assign nextWdata = selBusBeat ? writeLine[beatCount] : writeWord;

  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      HWDATA <= '0;
    end else if (HREADY) begin
      HWDATA <= nextWdata;                  // Word for the beat just accepted
    end
  end

endmodule

`default_nettype wire

/* fetchBuffer.sv */
/*
  Fetch buffer. Collects HRDATA beats into the line being fetched and
  keeps the last uncached read word
*/
`timescale 1ns/1ps
`default_nettype none

module fetchBuffer import ahbCachePkg::*; #(
  parameter int BeatsPerLine = 4,
  localparam int CountBits   = $clog2(BeatsPerLine)
) (
  input  logic                          HCLK,
  input  logic                          rstN,
  input  logic                          captureEn,
  input  logic                          isLine,       // Line fetch, else uncached
  input  logic [CountBits-1:0]          beatCountDelayed,
  input  wordT                          HRDATA,
  output wordT [BeatsPerLine-1:0]       fetchLine,
  output wordT                          readWord
);

  logic lineWr;
  logic wordWr;

  assign lineWr = captureEn & isLine;
  assign wordWr = captureEn & ~isLine;

  ////////////////////////////////////////////////////////////////////
  // Line storage, one slot per beat
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (lineWr) fetchLine[beatCountDelayed] <= HRDATA;   // Slot of data-phase beat
  end

  ////////////////////////////////////////////////////////////////////
  // Uncached read word
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      readWord <= '0;
    end else if (wordWr) begin
      readWord <= HRDATA;                   // Last load on the HREADY cycle
    end
  end

endmodule

`default_nettype wire

/* beatCounter.sv */
/*
  Line beat counter, address-phase index plus a copy one step behind
  for the data phase, and the final data beat flag
*/
`timescale 1ns/1ps
`default_nettype none

module beatCounter #(
  parameter int BeatsPerLine = 4,           // Power of two, 2 or more
  localparam int CountBits   = $clog2(BeatsPerLine)
) (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  logic                 cntEn,       // Address phase accepted
  input  logic                 cntReset,    // New operation starting
  output logic [CountBits-1:0] beatCount,
  output logic [CountBits-1:0] beatCountDelayed,
  output logic                 finalBeat
);

  localparam logic [CountBits-1:0] LastBeat = CountBits'(BeatsPerLine - 1);

  ////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rstN || cntReset) begin
      beatCount        <= '0;
      beatCountDelayed <= '0;
    end else if (cntEn) begin
      beatCount        <= beatCount + 1'b1;  // Wraps to 0 after last beat
      beatCountDelayed <= beatCount;         // Beat now in data phase
    end
  end

  // Last data beat of the line
  assign finalBeat = beatCountDelayed == LastBeat;

endmodule

`default_nettype wire

/* busCacheFsm.sv */
/*
  Cache bus controller. Sequences uncached single-word accesses and
  whole-line fetch and writeback bursts, drives AHB control and stalls
*/
`timescale 1ns/1ps
`default_nettype none

module busCacheFsm import ahbCachePkg::*; #(
  parameter int BeatsPerLine = 4,           // Power of two from 2 up
  parameter bit BurstEn      = 1'b1,        // SEQ beats and INCRx bursts
  localparam int CountBits   = $clog2(BeatsPerLine)
) (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  logic                 stall,       // Core pipeline stalled
  input  busOpT                busOp,       // Uncached request level
  input  cacheOpT              cacheOp,     // Line request level
  input  logic                 HREADY,
  input  logic [CountBits-1:0] beatCount,   // Address-phase beat
  input  logic                 finalBeat,   // Data phase of last beat
  output ahbCtrlT              ahbCtrl,
  output logic                 busStall,
  output logic                 cacheBusAck,
  output logic                 captureEn,   // Load HRDATA this cycle
  output logic                 selBusBeat,  // Address from beat index
  output logic                 cntEn,
  output logic                 cntReset
);

  typedef enum logic [2:0] {
    Idle, AdrPhase, DataPhase, Done, CacheFetch, CacheWriteback
  } stateT;

  // HBURST for a whole line
  localparam logic [2:0] LineBurst =
    (BeatsPerLine == 4)  ? 3'b011 :         // INCR4
    (BeatsPerLine == 8)  ? 3'b101 :         // INCR8
    (BeatsPerLine == 16) ? 3'b111 :         // INCR16
                           3'b001;          // INCR with open length

  stateT    state, nextState;
  logic     anyBusOp, anyCacheOp;
  logic     cacheAccess;
  logic     chainFetch;
  ahbTransT trans;
  logic     write;

  assign anyBusOp    = busOp != NoOp;
  assign anyCacheOp  = cacheOp != NoCacheOp;
  assign cacheAccess = (state == CacheFetch) | (state == CacheWriteback);
  // Last writeback beat with a fetch still asked for
  assign chainFetch  = (state == CacheWriteback) & finalBeat & cacheOp[1];

  ////////////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rstN) state <= Idle;
    else       state <= nextState;
  end

  always_comb begin
    nextState = state;
    case (state)
      Idle:       if (anyBusOp | anyCacheOp) nextState = AdrPhase;
      AdrPhase: begin
        if (HREADY) begin                   // NONSEQ accepted
          if (anyBusOp)        nextState = DataPhase;   // Uncached first
          else if (cacheOp[0]) nextState = CacheWriteback;
          else if (cacheOp[1]) nextState = CacheFetch;
          else                 nextState = Idle;
        end
      end
      DataPhase:  if (HREADY) nextState = Done;
      Done:       if (!stall) nextState = Idle;   // Result held for core
      CacheFetch: if (HREADY & finalBeat) nextState = Idle;
      CacheWriteback: begin
        if (HREADY & finalBeat) nextState = cacheOp[1] ? CacheFetch : Idle;
      end
      default:    nextState = Idle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Beat counter control
  ////////////////////////////////////////////////////////////////////
  assign cntReset = (state == Idle) & (nextState == AdrPhase);
  assign cntEn    = HREADY & ((nextState == CacheFetch) | (nextState == CacheWriteback));

  ////////////////////////////////////////////////////////////////////
  // AHB control
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    trans = TransIdle;
    write = 1'b0;
    if (state == AdrPhase) begin
      trans = TransNonseq;                  // Held through wait states
      write = anyBusOp ? (busOp == WriteOp) : cacheOp[0];
    end else if (chainFetch) begin
      trans = TransNonseq;                  // Fetch beat 0 overlaps last write
    end else if (cacheAccess & (beatCount != '0)) begin
      trans = BurstEn ? TransSeq : TransNonseq;
      write = state == CacheWriteback;
    end
  end

  assign ahbCtrl.trans = trans;
  assign ahbCtrl.write = write;
  // Burst type only on line beats
  assign ahbCtrl.burst = (BurstEn && selBusBeat && trans != TransIdle) ? LineBurst : 3'b000;

  ////////////////////////////////////////////////////////////////////
  // Core and cache status
  ////////////////////////////////////////////////////////////////////
  assign busStall = ((state == Idle) & (anyBusOp | anyCacheOp)) |
                    (state == AdrPhase) | (state == DataPhase) |
                    (cacheAccess & ~finalBeat);

  assign cacheBusAck = cacheAccess & HREADY & finalBeat;   // One-cycle pulse

  assign captureEn  = ((state == DataPhase) & (busOp == ReadOp)) |
                      ((state == CacheFetch) & HREADY);
  assign selBusBeat = cacheAccess | ((state == AdrPhase) & ~anyBusOp);

endmodule

`default_nettype wire

/* ahbCachePkg.sv */
/*
  AHB cache bus types: bus word, core and cache request encodings,
  and the address-phase control bundle
*/
`default_nettype none

package ahbCachePkg;

  ////////////////////////////////////////////////////////////////////
  // Bus word
  ////////////////////////////////////////////////////////////////////
  localparam int WordBits = 32;             // AHB data width

  typedef logic [WordBits-1:0] wordT;

  ////////////////////////////////////////////////////////////////////
  // Requests
  ////////////////////////////////////////////////////////////////////
  // Uncached core access, read on bit 1 and write on bit 0
  typedef enum logic [1:0] {
    NoOp    = 2'b00,
    WriteOp = 2'b01,
    ReadOp  = 2'b10
  } busOpT;

  // Cache line op, fetch on bit 1 and writeback on bit 0
  // Both bits set chains a writeback into a fetch
  typedef enum logic [1:0] {
    NoCacheOp   = 2'b00,
    WritebackOp = 2'b01,
    FetchOp     = 2'b10
  } cacheOpT;

  ////////////////////////////////////////////////////////////////////
  // AHB address-phase control
  ////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    TransIdle   = 2'b00,
    TransBusy   = 2'b01,
    TransNonseq = 2'b10,
    TransSeq    = 2'b11
  } ahbTransT;

  typedef struct packed {
    ahbTransT   trans;                      // HTRANS
    logic       write;                      // HWRITE
    logic [2:0] burst;                      // HBURST
  } ahbCtrlT;

endpackage

`default_nettype wire
